// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0 -Wno-fatal
TOP       = core_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/core_tests.svh
`ifndef CORE_TESTS_SVH
`define CORE_TESTS_SVH

// funct3 codes of the RV32I spec
localparam int FN_ADD  = 0;
localparam int FN_SLT  = 2;
localparam int FN_SLTU = 3;
localparam int FN_XOR  = 4;
localparam int FN_OR   = 6;
localparam int FN_AND  = 7;
localparam int B_EQ    = 0;
localparam int B_NE    = 1;
localparam int B_LT    = 4;
localparam int B_GE    = 5;
localparam int B_LTU   = 6;
localparam int B_GEU   = 7;

function automatic logic [31:0] r_type(input int f7, input int f3, input int rd,
	input int rs1, input int rs2);
	return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
endfunction

function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
	input int rd, input int op);
	return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
endfunction

function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
	return i_type(imm, rs1, 0, rd, 7'h13);
endfunction

function automatic logic [31:0] lw(input int rd, input int rs1, input int imm);
	return i_type(imm, rs1, 2, rd, 7'h03);
endfunction

function automatic logic [31:0] jalr(input int rd, input int rs1, input int imm);
	return i_type(imm, rs1, 0, rd, 7'h67);
endfunction

function automatic logic [31:0] sw(input int rs2, input int rs1, input int imm);
	return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] branch(input int f3, input int rs1, input int rs2,
	input int off);
	return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] jal(input int rd, input int off);
	return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
endfunction

function automatic logic [31:0] lui(input int rd, input int imm20);
	return {imm20[19:0], rd[4:0], 7'h37};
endfunction

function automatic logic [31:0] auipc(input int rd, input int imm20);
	return {imm20[19:0], rd[4:0], 7'h17};
endfunction

// an instruction followed by a counter bump on rd
task automatic emit_marked(input logic [31:0] inst, input int rd);
	emit(inst);
	emit(addi(rd, rd, 1));
endtask

task automatic arith_ops();
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] exp [0:11];
	a = 32'd100;
	b = 32'(-7);
	new_program();
	emit(addi(1, 0, 100));
	emit(addi(2, 0, -7));
	emit(r_type(0, FN_ADD, 3, 1, 2));
	emit(r_type(32, FN_ADD, 4, 1, 2));
	emit(r_type(0, FN_AND, 5, 1, 2));
	emit(r_type(0, FN_OR, 6, 1, 2));
	emit(r_type(0, FN_XOR, 7, 1, 2));
	emit(r_type(0, FN_SLT, 8, 2, 1));
	emit(r_type(0, FN_SLT, 9, 1, 2));
	emit(r_type(0, FN_SLTU, 10, 2, 1));
	emit(r_type(0, FN_SLTU, 11, 1, 2));
	// x0 targets
	emit(addi(0, 1, 5));
	emit(r_type(0, FN_ADD, 0, 1, 1));
	for (int r = 0; r < 12; r++) begin
		emit(sw(r, 0, 'h100 + 4 * r));
	end
	emit(EBREAK_WORD);
	run_program("arithmetic");
	exp[0] = 32'd0;
	exp[1] = a;
	exp[2] = b;
	exp[3] = a + b;
	exp[4] = a - b;
	exp[5] = a & b;
	exp[6] = a | b;
	exp[7] = a ^ b;
	exp[8] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
	exp[9] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
	exp[10] = (b < a) ? 32'd1 : 32'd0;
	exp[11] = (a < b) ? 32'd1 : 32'd0;
	for (int r = 0; r < 12; r++) begin
		check_word('h100 + 4 * r, exp[r]);
	end
	check("invalid_o", 32'(invalid), 32'd0);
endtask

task automatic load_store();
	int base;
	new_program();
	dmem[160] = 32'h5a5a_1234;
	emit(addi(1, 0, 'h123));
	emit(lui(2, 'habcde));
	emit(addi(2, 2, 'h456));
	emit(sw(1, 0, 'h200));
	emit(sw(2, 0, 'h204));
	emit(lw(3, 0, 'h200));
	emit(lw(4, 0, 'h204));
	emit(lw(5, 0, 'h280));
	// negative offsets from a base register
	emit(addi(6, 0, 'h310));
	emit(sw(3, 6, -16));
	emit(sw(4, 6, -12));
	emit(sw(5, 6, -8));
	emit(lw(7, 6, -4));
	emit(sw(7, 0, 'h3fc));
	emit(EBREAK_WORD);
	base = xfers;
	run_program("load store");
	check_word('h200, 32'h0000_0123);
	check_word('h204, 32'habcd_e456);
	check_word('h300, 32'h0000_0123);
	check_word('h304, 32'habcd_e456);
	check_word('h308, 32'h5a5a_1234);
	check_word('h3fc, fill_word('h30c));
	check("apb transfer count", 32'(xfers - base), 32'd10);
	check("invalid_o", 32'(invalid), 32'd0);
endtask

task automatic control_flow();
	int jal_pc;
	int jalr_pc;
	int land_pc;
	new_program();
	emit(addi(1, 0, 5));
	emit(addi(2, 0, -3));
	emit(addi(3, 0, 5));
	emit(addi(13, 0, 3));
	// taken branches leave x10 at zero
	emit_marked(branch(B_EQ, 1, 3, 8), 10);
	emit_marked(branch(B_NE, 1, 2, 8), 10);
	emit_marked(branch(B_LT, 2, 1, 8), 10);
	emit_marked(branch(B_GE, 1, 2, 8), 10);
	emit_marked(branch(B_LTU, 1, 2, 8), 10);
	emit_marked(branch(B_GEU, 2, 1, 8), 10);
	// not taken branches bump x11 six times
	emit_marked(branch(B_EQ, 1, 2, 8), 11);
	emit_marked(branch(B_NE, 1, 3, 8), 11);
	emit_marked(branch(B_LT, 1, 2, 8), 11);
	emit_marked(branch(B_GE, 2, 1, 8), 11);
	emit_marked(branch(B_LTU, 2, 1, 8), 11);
	emit_marked(branch(B_GEU, 1, 2, 8), 11);
	// backward loop runs three times
	emit(addi(12, 12, 1));
	emit(branch(B_LT, 12, 13, -4));
	jal_pc = here();
	emit_marked(jal(20, 8), 10);
	// odd jalr sum lands with bit 0 dropped
	jalr_pc = here() + 4;
	emit(addi(21, 0, jalr_pc + 5));
	emit_marked(jalr(22, 21, 4), 10);
	// auipc records the landing pc
	land_pc = here();
	emit(auipc(23, 0));
	emit(sw(10, 0, 'h100));
	emit(sw(11, 0, 'h104));
	emit(sw(12, 0, 'h108));
	emit(sw(20, 0, 'h10c));
	emit(sw(22, 0, 'h110));
	emit(sw(23, 0, 'h114));
	emit(EBREAK_WORD);
	run_program("control flow");
	check_word('h100, 32'd0);
	check_word('h104, 32'd6);
	check_word('h108, 32'd3);
	check_word('h10c, 32'(jal_pc + 4));
	check_word('h110, 32'(jalr_pc + 4));
	check_word('h114, 32'(land_pc));
	check("invalid_o", 32'(invalid), 32'd0);
endtask

task automatic upper_imm();
	logic [31:0] p3;
	logic [31:0] p4;
	new_program();
	emit(lui(1, 'h12345));
	emit(lui(2, 'hfffff));
	p3 = 32'(here());
	emit(auipc(3, 'h00010));
	p4 = 32'(here());
	emit(auipc(4, 'h80000));
	for (int r = 1; r < 5; r++) begin
		emit(sw(r, 0, 'h100 + 4 * r));
	end
	emit(EBREAK_WORD);
	run_program("upper immediates");
	check_word('h104, 32'h12345 << 12);
	check_word('h108, 32'hfffff << 12);
	check_word('h10c, (32'h00010 << 12) + p3);
	check_word('h110, (32'h80000 << 12) + p4);
	check("invalid_o", 32'(invalid), 32'd0);
endtask

task automatic count_retires(output int n);
	n = 0;
	repeat (20) begin
		@(posedge clk);
		#1;
		if (retire) begin
			n++;
		end
	end
endtask

task automatic halt_cases();
	int stop_pc;
	int seen;
	new_program();
	emit(addi(1, 0, 1));
	emit(addi(1, 1, 1));
	emit(sw(1, 0, 'h100));
	stop_pc = here();
	emit(EBREAK_WORD);
	emit(sw(1, 0, 'h104));
	run_program("ebreak");
	check("halt_o after ebreak", 32'(halt), 32'd1);
	check("invalid_o after ebreak", 32'(invalid), 32'd0);
	check("pc_o after ebreak", pc, 32'(stop_pc));
	check_word('h100, 32'd2);
	check_word('h104, fill_word('h104));
	count_retires(seen);
	check("retire_o pulses after ebreak", 32'(seen), 32'd0);
	// fence opcode lies outside the subset
	new_program();
	emit(addi(1, 0, 7));
	stop_pc = here();
	emit(32'h0ff0_000f);
	emit(sw(1, 0, 'h100));
	emit(EBREAK_WORD);
	run_program("invalid opcode");
	check("halt_o after invalid", 32'(halt), 32'd1);
	check("invalid_o after invalid", 32'(invalid), 32'd1);
	check("pc_o after invalid", pc, 32'(stop_pc));
	check_word('h100, fill_word('h100));
	count_retires(seen);
	check("retire_o pulses after invalid", 32'(seen), 32'd0);
endtask

`endif

// File: bench/core_tb.sv
module core_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

	logic        clk;
	logic        rst;
	logic [31:0] imem_addr;
	logic [31:0] imem_data;
	logic [31:0] paddr;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic        pready;
	logic [31:0] pc;
	logic        retire;
	logic        halt;
	logic        invalid;

	logic [31:0] imem [0:255];
	logic [31:0] dmem [0:255];
	int          prog_idx;
	int          checks;
	int          errors;
	int          xfers;

	// apb slave and monitor state
	logic [31:0] rng;
	int          wait_cnt;
	logic        was_setup;
	logic        was_wait;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic        held_write;

	rv_core DUT (
		.clk         (clk),
		.rst         (rst),
		.imem_addr_o (imem_addr),
		.imem_data_i (imem_data),
		.paddr_o     (paddr),
		.psel_o      (psel),
		.penable_o   (penable),
		.pwrite_o    (pwrite),
		.pwdata_o    (pwdata),
		.prdata_i    (prdata),
		.pready_i    (pready),
		.pc_o        (pc),
		.retire_o    (retire),
		.halt_o      (halt),
		.invalid_o   (invalid)
	);

	// combinational instruction port
	assign imem_data = imem[imem_addr[9:2]];

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// data memory background is unique per byte address
	function automatic logic [31:0] fill_word(input int addr);
		return 32'hc0de_0000 ^ addr;
	endfunction

	task automatic check_word(input int addr, input logic [31:0] exp);
		check($sformatf("dmem[%h]", addr), dmem[addr[9:2]], exp);
	endtask

	task automatic new_program();
		for (int i = 0; i < 256; i++) begin
			imem[i] = EBREAK_WORD;
			dmem[i] = fill_word(i * 4);
		end
		prog_idx = 0;
	endtask

	task automatic emit(input logic [31:0] inst);
		imem[prog_idx] = inst;
		prog_idx++;
	endtask

	function automatic int here();
		return prog_idx * 4;
	endfunction

	task automatic reset_core();
		@(posedge clk);
		#1;
		rst = 1'b0;
		repeat (16) @(posedge clk);
		#1;
		check("psel_o in reset", 32'(psel), 32'd0);
		check("penable_o in reset", 32'(penable), 32'd0);
		check("retire_o in reset", 32'(retire), 32'd0);
		check("halt_o in reset", 32'(halt), 32'd0);
		check("invalid_o in reset", 32'(invalid), 32'd0);
		check("pc_o in reset", pc, 32'h0000_0000);
		rst = 1'b1;
	endtask

	task automatic wait_halt(input string what);
		int n;
		n = 0;
		while (!halt && n < 2000) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (!halt) begin
			errors++;
			$display("timeout: program %s did not halt within 2000 cycles", what);
		end
	endtask

	task automatic run_program(input string what);
		reset_core();
		wait_halt(what);
	endtask

	// slave answers and protocol checks run 1 ns after the edge
	always @(posedge clk) begin
		#1;
		if (was_setup) begin
			check("psel_o after setup", 32'(psel), 32'd1);
			check("penable_o after setup", 32'(penable), 32'd1);
		end else if (was_wait) begin
			check("psel_o in wait", 32'(psel), 32'd1);
			check("penable_o in wait", 32'(penable), 32'd1);
			check("paddr_o in wait", paddr, held_addr);
			check("pwrite_o in wait", 32'(pwrite), 32'(held_write));
			if (held_write) begin
				check("pwdata_o in wait", pwdata, held_wdata);
			end
		end else if (psel && penable) begin
			errors++;
			$display("apb error at %0t ns: access phase without a setup cycle", $time);
		end
		pready = 1'b0;
		if (psel && !penable) begin
			rng = xorshift(rng);
			wait_cnt = int'(rng[1:0]);
			xfers++;
		end else if (psel && penable) begin
			if (wait_cnt == 0) begin
				pready = 1'b1;
				if (pwrite) begin
					dmem[paddr[9:2]] = pwdata;
				end else begin
					prdata = dmem[paddr[9:2]];
				end
			end else begin
				wait_cnt--;
			end
		end
		was_setup = psel && !penable;
		was_wait = psel && penable && !pready;
		held_addr = paddr;
		held_write = pwrite;
		held_wdata = pwdata;
	end

	`include "core_tests.svh"

	initial begin
		rst = 1'b0;
		pready = 1'b0;
		prdata = 32'd0;
		checks = 0;
		errors = 0;
		xfers = 0;
		rng = 32'h20c2_51d2;
		wait_cnt = 0;
		was_setup = 1'b0;
		was_wait = 1'b0;
		held_addr = 32'd0;
		held_wdata = 32'd0;
		held_write = 1'b0;
		new_program();
		arith_ops();
		load_store();
		control_flow();
		upper_imm();
		halt_cases();
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: flist.f
+incdir+bench
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/stage_if.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/reg_file.sv
hdl/execute_stage.sv
hdl/mem_stage.sv
hdl/rv_core.sv
bench/core_tb.sv

// File: hdl/core_pkg.sv
package core_pkg;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		MEM_NONE,
		MEM_LOAD,
		MEM_STORE
	} mem_op_e;

	// writeback source
	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK
	} wb_sel_e;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		ACCESS
	} apb_state_e;

endpackage

// File: hdl/decode_stage.sv
module decode_stage (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  valid_i,
	input  rv_isa_pkg::inst_t     inst_i,
	input  rv_isa_pkg::word_t     pc_i,
	output rv_isa_pkg::reg_idx_t  rs1_addr_o,
	output rv_isa_pkg::reg_idx_t  rs2_addr_o,
	input  rv_isa_pkg::word_t     rs1_val_i,
	input  rv_isa_pkg::word_t     rs2_val_i,
	dec_ex_if.dec                 dec
);

	rv_isa_pkg::opcode_t opcode;
	rv_isa_pkg::funct3_t funct3;
	rv_isa_pkg::funct7_t funct7;
	rv_isa_pkg::word_t   imm_i, imm_s, imm_b, imm_u, imm_j;
	rv_isa_pkg::word_t   imm;
	core_pkg::alu_op_e   alu_op;
	core_pkg::mem_op_e   mem_op;
	core_pkg::wb_sel_e   wb_sel;
	logic                use_imm, use_pc, rd_wen;
	logic                is_branch, is_jal, is_jalr;
	logic                invalid, halt;

	assign opcode     = inst_i[6:0];
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u = {inst_i[31:12], 12'b0};
	assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21],
		1'b0};

	always_comb begin
		imm       = imm_i;
		alu_op    = core_pkg::ALU_ADD;
		mem_op    = core_pkg::MEM_NONE;
		wb_sel    = core_pkg::WB_ALU;
		use_imm   = 1'b1;
		use_pc    = 1'b0;
		rd_wen    = 1'b0;
		is_branch = 1'b0;
		is_jal    = 1'b0;
		is_jalr   = 1'b0;
		invalid   = 1'b0;
		halt      = 1'b0;
		case (opcode)
			rv_isa_pkg::OP_LUI: begin
				imm    = imm_u;
				alu_op = core_pkg::ALU_PASS_B;
				rd_wen = 1'b1;
			end
			rv_isa_pkg::OP_AUIPC: begin
				imm    = imm_u;
				use_pc = 1'b1;
				rd_wen = 1'b1;
			end
			rv_isa_pkg::OP_JAL: begin
				imm    = imm_j;
				is_jal = 1'b1;
				wb_sel = core_pkg::WB_LINK;
				rd_wen = 1'b1;
			end
			rv_isa_pkg::OP_JALR: begin
				is_jalr = 1'b1;
				wb_sel  = core_pkg::WB_LINK;
				rd_wen  = 1'b1;
				invalid = funct3 != rv_isa_pkg::F3_JALR;
			end
			rv_isa_pkg::OP_BRANCH: begin
				imm       = imm_b;
				is_branch = 1'b1;
				// 010 and 011 are not branches
				invalid   = funct3[2:1] == 2'b01;
			end
			rv_isa_pkg::OP_LOAD: begin
				mem_op  = core_pkg::MEM_LOAD;
				wb_sel  = core_pkg::WB_MEM;
				rd_wen  = 1'b1;
				invalid = funct3 != rv_isa_pkg::F3_LW;
			end
			rv_isa_pkg::OP_STORE: begin
				imm     = imm_s;
				mem_op  = core_pkg::MEM_STORE;
				invalid = funct3 != rv_isa_pkg::F3_SW;
			end
			rv_isa_pkg::OP_IMM: begin
				rd_wen  = 1'b1;
				invalid = funct3 != rv_isa_pkg::F3_ADD;
			end
			rv_isa_pkg::OP_REG: begin
				use_imm = 1'b0;
				rd_wen  = 1'b1;
				if (funct7 == rv_isa_pkg::F7_BASE) begin
					case (funct3)
						rv_isa_pkg::F3_ADD:  alu_op = core_pkg::ALU_ADD;
						rv_isa_pkg::F3_AND:  alu_op = core_pkg::ALU_AND;
						rv_isa_pkg::F3_OR:   alu_op = core_pkg::ALU_OR;
						rv_isa_pkg::F3_XOR:  alu_op = core_pkg::ALU_XOR;
						rv_isa_pkg::F3_SLT:  alu_op = core_pkg::ALU_SLT;
						rv_isa_pkg::F3_SLTU: alu_op = core_pkg::ALU_SLTU;
						default:             invalid = 1'b1;
					endcase
				end else if (funct7 == rv_isa_pkg::F7_SUB && funct3 == rv_isa_pkg::F3_ADD) begin
					alu_op = core_pkg::ALU_SUB;
				end else begin
					invalid = 1'b1;
				end
			end
			default: begin
				// ebreak runs as a nop that stops the core
				if (inst_i == rv_isa_pkg::INST_EBREAK) begin
					halt = 1'b1;
				end else begin
					invalid = 1'b1;
				end
			end
		endcase
		// nothing may change state for a bad encoding
		if (invalid) begin
			rd_wen    = 1'b0;
			mem_op    = core_pkg::MEM_NONE;
			is_branch = 1'b0;
			is_jal    = 1'b0;
			is_jalr   = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= valid_i;
		end
	end

	always_ff @(posedge clk) begin
		if (valid_i) begin
			dec.pc        <= pc_i;
			dec.rs1_val   <= rs1_val_i;
			dec.rs2_val   <= rs2_val_i;
			dec.imm       <= imm;
			dec.alu_op    <= alu_op;
			dec.use_imm   <= use_imm;
			dec.use_pc    <= use_pc;
			dec.mem_op    <= mem_op;
			dec.wb_sel    <= wb_sel;
			dec.rd        <= inst_i[11:7];
			dec.rd_wen    <= rd_wen;
			dec.is_branch <= is_branch;
			dec.is_jal    <= is_jal;
			dec.is_jalr   <= is_jalr;
			dec.funct3    <= funct3;
			dec.invalid   <= invalid;
			dec.halt      <= halt;
		end
	end

endmodule

// File: hdl/execute_stage.sv
module execute_stage (
	input  logic               clk,
	input  logic               rst,
	dec_ex_if.ex               dec,
	ex_mem_if.ex               exm,
	output logic               redirect_valid_o,
	output rv_isa_pkg::word_t  redirect_pc_o
);

	rv_isa_pkg::word_t alu_a, alu_b, alu_y;
	rv_isa_pkg::word_t target;
	logic              taken;
	logic              jump;

	assign alu_a = dec.use_pc ? dec.pc : dec.rs1_val;
	assign alu_b = dec.use_imm ? dec.imm : dec.rs2_val;

	always_comb begin
		case (dec.alu_op)
			core_pkg::ALU_ADD:  alu_y = alu_a + alu_b;
			core_pkg::ALU_SUB:  alu_y = alu_a - alu_b;
			core_pkg::ALU_AND:  alu_y = alu_a & alu_b;
			core_pkg::ALU_OR:   alu_y = alu_a | alu_b;
			core_pkg::ALU_XOR:  alu_y = alu_a ^ alu_b;
			core_pkg::ALU_SLT:  alu_y = {31'b0, $signed(alu_a) < $signed(alu_b)};
			core_pkg::ALU_SLTU: alu_y = {31'b0, alu_a < alu_b};
			default:            alu_y = alu_b;
		endcase
	end

	// branch compare on the register values
	always_comb begin
		case (dec.funct3)
			rv_isa_pkg::F3_BEQ:  taken = dec.rs1_val == dec.rs2_val;
			rv_isa_pkg::F3_BNE:  taken = dec.rs1_val != dec.rs2_val;
			rv_isa_pkg::F3_BLT:  taken = $signed(dec.rs1_val) < $signed(dec.rs2_val);
			rv_isa_pkg::F3_BGE:  taken = $signed(dec.rs1_val) >= $signed(dec.rs2_val);
			rv_isa_pkg::F3_BLTU: taken = dec.rs1_val < dec.rs2_val;
			rv_isa_pkg::F3_BGEU: taken = dec.rs1_val >= dec.rs2_val;
			default:             taken = 1'b0;
		endcase
	end

	assign jump   = dec.is_jal || dec.is_jalr || (dec.is_branch && taken);
	assign target = dec.is_jalr ? ((dec.rs1_val + dec.imm) & ~32'd1) : dec.pc + dec.imm;

	always_ff @(posedge clk) begin
		if (!rst) begin
			exm.valid        <= 1'b0;
			redirect_valid_o <= 1'b0;
		end else begin
			exm.valid        <= dec.valid;
			redirect_valid_o <= dec.valid && jump;
		end
	end

	always_ff @(posedge clk) begin
		if (dec.valid) begin
			exm.alu_result <= alu_y;
			exm.store_data <= dec.rs2_val;
			exm.link       <= dec.pc + 32'd4;
			exm.mem_op     <= dec.mem_op;
			exm.wb_sel     <= dec.wb_sel;
			exm.rd         <= dec.rd;
			exm.rd_wen     <= dec.rd_wen;
			exm.halt       <= dec.halt || dec.invalid;
			exm.invalid    <= dec.invalid;
			redirect_pc_o  <= target;
		end
	end

endmodule

// File: hdl/fetch_stage.sv
module fetch_stage (
	input  logic               clk,
	input  logic               rst,
	input  logic               retire_i,
	input  logic               halt_i,
	input  logic               redirect_valid_i,
	input  rv_isa_pkg::word_t  redirect_pc_i,
	input  rv_isa_pkg::inst_t  imem_data_i,
	output rv_isa_pkg::word_t  imem_addr_o,
	output rv_isa_pkg::word_t  pc_o,
	output rv_isa_pkg::inst_t  inst_o,
	output logic               valid_o
);

	rv_isa_pkg::word_t pc_q;
	rv_isa_pkg::word_t redir_pc;
	logic              redir_pending;
	logic              in_flight;
	logic              fetch_now;

	// one instruction at a time, none once halted
	assign fetch_now = !in_flight && !halt_i;

	assign imem_addr_o = pc_q;
	assign pc_o        = pc_q;

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc_q          <= rv_isa_pkg::RESET_PC;
			in_flight     <= 1'b0;
			redir_pending <= 1'b0;
			valid_o       <= 1'b0;
		end else begin
			valid_o <= fetch_now;
			if (fetch_now) begin
				in_flight <= 1'b1;
			end else if (retire_i) begin
				in_flight <= 1'b0;
			end
			if (redirect_valid_i) begin
				redir_pending <= 1'b1;
			end else if (retire_i) begin
				redir_pending <= 1'b0;
			end
			// pc stays on the halting instruction
			if (retire_i && !halt_i) begin
				pc_q <= redir_pending ? redir_pc : pc_q + 32'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fetch_now) begin
			inst_o <= imem_data_i;
		end
		if (redirect_valid_i) begin
			redir_pc <= redirect_pc_i;
		end
	end

endmodule

// File: hdl/mem_stage.sv
module mem_stage (
	input  logic                  clk,
	input  logic                  rst,
	ex_mem_if.mem                 exm,
	output rv_isa_pkg::word_t     paddr_o,
	output logic                  psel_o,
	output logic                  penable_o,
	output logic                  pwrite_o,
	output rv_isa_pkg::word_t     pwdata_o,
	input  rv_isa_pkg::word_t     prdata_i,
	input  logic                  pready_i,
	output logic                  wen_o,
	output rv_isa_pkg::reg_idx_t  waddr_o,
	output rv_isa_pkg::word_t     wdata_o,
	output logic                  retire_o,
	output logic                  halt_o,
	output logic                  invalid_o
);

	core_pkg::apb_state_e state;
	rv_isa_pkg::word_t    wb_data;
	logic                 start_xfer;
	logic                 retire_now;

	assign start_xfer = state == core_pkg::IDLE && exm.valid && exm.mem_op != core_pkg::MEM_NONE;
	// non-memory ops finish at once, transfers on the pready edge
	assign retire_now = (state == core_pkg::IDLE && exm.valid && exm.mem_op == core_pkg::MEM_NONE)
		|| (state == core_pkg::ACCESS && pready_i);

	assign psel_o    = state != core_pkg::IDLE;
	assign penable_o = state == core_pkg::ACCESS;

	always_comb begin
		case (exm.wb_sel)
			core_pkg::WB_MEM:  wb_data = prdata_i;
			core_pkg::WB_LINK: wb_data = exm.link;
			default:           wb_data = exm.alu_result;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state     <= core_pkg::IDLE;
			retire_o  <= 1'b0;
			wen_o     <= 1'b0;
			halt_o    <= 1'b0;
			invalid_o <= 1'b0;
		end else begin
			retire_o <= retire_now;
			wen_o    <= retire_now && exm.rd_wen;
			if (retire_now) begin
				halt_o    <= halt_o || exm.halt;
				invalid_o <= invalid_o || exm.invalid;
			end
			case (state)
				core_pkg::IDLE:   if (start_xfer) state <= core_pkg::SETUP;
				core_pkg::SETUP:  state <= core_pkg::ACCESS;
				core_pkg::ACCESS: if (pready_i) state <= core_pkg::IDLE;
				default:          state <= core_pkg::IDLE;
			endcase
		end
	end

	// bus payload held for the whole transfer
	always_ff @(posedge clk) begin
		if (start_xfer) begin
			paddr_o  <= exm.alu_result;
			pwrite_o <= exm.mem_op == core_pkg::MEM_STORE;
			pwdata_o <= exm.store_data;
		end
		if (retire_now) begin
			waddr_o <= exm.rd;
			wdata_o <= wb_data;
		end
	end

endmodule

// File: hdl/reg_file.sv
module reg_file (
	input  logic                  clk,
	input  logic                  rst,
	input  rv_isa_pkg::reg_idx_t  rs1_addr_i,
	input  rv_isa_pkg::reg_idx_t  rs2_addr_i,
	output rv_isa_pkg::word_t     rs1_val_o,
	output rv_isa_pkg::word_t     rs2_val_o,
	input  logic                  wen_i,
	input  rv_isa_pkg::reg_idx_t  waddr_i,
	input  rv_isa_pkg::word_t     wdata_i
);

	// x1..x31, x0 has no storage
	rv_isa_pkg::word_t regs [31:1];

	assign rs1_val_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
	assign rs2_val_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

// File: hdl/rv_core.sv
module rv_core (
	input  logic               clk,
	input  logic               rst,
	output rv_isa_pkg::word_t  imem_addr_o,
	input  rv_isa_pkg::inst_t  imem_data_i,
	output rv_isa_pkg::word_t  paddr_o,
	output logic               psel_o,
	output logic               penable_o,
	output logic               pwrite_o,
	output rv_isa_pkg::word_t  pwdata_o,
	input  rv_isa_pkg::word_t  prdata_i,
	input  logic               pready_i,
	output rv_isa_pkg::word_t  pc_o,
	output logic               retire_o,
	output logic               halt_o,
	output logic               invalid_o
);

	rv_isa_pkg::inst_t    if_inst;
	logic                 if_valid;
	rv_isa_pkg::reg_idx_t rs1_addr, rs2_addr;
	rv_isa_pkg::word_t    rs1_val, rs2_val;
	logic                 redirect_valid;
	rv_isa_pkg::word_t    redirect_pc;
	logic                 rf_wen;
	rv_isa_pkg::reg_idx_t rf_waddr;
	rv_isa_pkg::word_t    rf_wdata;

	dec_ex_if dec_ex ();
	ex_mem_if ex_mem ();

	fetch_stage u_fetch (
		.clk              (clk),
		.rst              (rst),
		.retire_i         (retire_o),
		.halt_i           (halt_o),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.imem_data_i      (imem_data_i),
		.imem_addr_o      (imem_addr_o),
		.pc_o             (pc_o),
		.inst_o           (if_inst),
		.valid_o          (if_valid)
	);

	decode_stage u_decode (
		.clk        (clk),
		.rst        (rst),
		.valid_i    (if_valid),
		.inst_i     (if_inst),
		.pc_i       (pc_o),
		.rs1_addr_o (rs1_addr),
		.rs2_addr_o (rs2_addr),
		.rs1_val_i  (rs1_val),
		.rs2_val_i  (rs2_val),
		.dec        (dec_ex.dec)
	);

	reg_file u_regs (
		.clk        (clk),
		.rst        (rst),
		.rs1_addr_i (rs1_addr),
		.rs2_addr_i (rs2_addr),
		.rs1_val_o  (rs1_val),
		.rs2_val_o  (rs2_val),
		.wen_i      (rf_wen),
		.waddr_i    (rf_waddr),
		.wdata_i    (rf_wdata)
	);

	execute_stage u_execute (
		.clk              (clk),
		.rst              (rst),
		.dec              (dec_ex.ex),
		.exm              (ex_mem.ex),
		.redirect_valid_o (redirect_valid),
		.redirect_pc_o    (redirect_pc)
	);

	mem_stage u_mem (
		.clk       (clk),
		.rst       (rst),
		.exm       (ex_mem.mem),
		.paddr_o   (paddr_o),
		.psel_o    (psel_o),
		.penable_o (penable_o),
		.pwrite_o  (pwrite_o),
		.pwdata_o  (pwdata_o),
		.prdata_i  (prdata_i),
		.pready_i  (pready_i),
		.wen_o     (rf_wen),
		.waddr_o   (rf_waddr),
		.wdata_o   (rf_wdata),
		.retire_o  (retire_o),
		.halt_o    (halt_o),
		.invalid_o (invalid_o)
	);

endmodule

// File: hdl/rv_isa_pkg.sv
package rv_isa_pkg;

	// instruction level widths
	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0]  reg_idx_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [2:0]  funct3_t;
	typedef logic [6:0]  funct7_t;

	// major opcodes, inst[6:0]
	localparam opcode_t OP_LUI    = 7'b0110111;
	localparam opcode_t OP_AUIPC  = 7'b0010111;
	localparam opcode_t OP_JAL    = 7'b1101111;
	localparam opcode_t OP_JALR   = 7'b1100111;
	localparam opcode_t OP_BRANCH = 7'b1100011;
	localparam opcode_t OP_LOAD   = 7'b0000011;
	localparam opcode_t OP_STORE  = 7'b0100011;
	localparam opcode_t OP_IMM    = 7'b0010011;
	localparam opcode_t OP_REG    = 7'b0110011;

	// branch compares
	localparam funct3_t F3_BEQ  = 3'b000;
	localparam funct3_t F3_BNE  = 3'b001;
	localparam funct3_t F3_BLT  = 3'b100;
	localparam funct3_t F3_BGE  = 3'b101;
	localparam funct3_t F3_BLTU = 3'b110;
	localparam funct3_t F3_BGEU = 3'b111;

	// word access only
	localparam funct3_t F3_LW = 3'b010;
	localparam funct3_t F3_SW = 3'b010;

	// alu group, shared by OP_IMM and OP_REG
	localparam funct3_t F3_ADD  = 3'b000;
	localparam funct3_t F3_AND  = 3'b111;
	localparam funct3_t F3_OR   = 3'b110;
	localparam funct3_t F3_XOR  = 3'b100;
	localparam funct3_t F3_SLT  = 3'b010;
	localparam funct3_t F3_SLTU = 3'b011;

	localparam funct3_t F3_JALR = 3'b000;

	localparam funct7_t F7_BASE = 7'b0000000;
	localparam funct7_t F7_SUB  = 7'b0100000;

	localparam inst_t INST_EBREAK = 32'h0010_0073;

	localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// File: hdl/stage_if.sv
// decode to execute
interface dec_ex_if;
	logic                  valid;
	rv_isa_pkg::word_t     pc;
	rv_isa_pkg::word_t     rs1_val;
	rv_isa_pkg::word_t     rs2_val;
	rv_isa_pkg::word_t     imm;
	core_pkg::alu_op_e     alu_op;
	logic                  use_imm;
	logic                  use_pc;
	core_pkg::mem_op_e     mem_op;
	core_pkg::wb_sel_e     wb_sel;
	rv_isa_pkg::reg_idx_t  rd;
	logic                  rd_wen;
	logic                  is_branch;
	logic                  is_jal;
	logic                  is_jalr;
	rv_isa_pkg::funct3_t   funct3;
	logic                  invalid;
	logic                  halt;

	modport dec (output valid, pc, rs1_val, rs2_val, imm, alu_op, use_imm, use_pc, mem_op,
		wb_sel, rd, rd_wen, is_branch, is_jal, is_jalr, funct3, invalid, halt);
	modport ex (input valid, pc, rs1_val, rs2_val, imm, alu_op, use_imm, use_pc, mem_op,
		wb_sel, rd, rd_wen, is_branch, is_jal, is_jalr, funct3, invalid, halt);
endinterface

// execute to memory
interface ex_mem_if;
	logic                  valid;
	rv_isa_pkg::word_t     alu_result;
	rv_isa_pkg::word_t     store_data;
	rv_isa_pkg::word_t     link;
	core_pkg::mem_op_e     mem_op;
	core_pkg::wb_sel_e     wb_sel;
	rv_isa_pkg::reg_idx_t  rd;
	logic                  rd_wen;
	logic                  halt;
	logic                  invalid;

	modport ex (output valid, alu_result, store_data, link, mem_op, wb_sel, rd, rd_wen,
		halt, invalid);
	modport mem (input valid, alu_result, store_data, link, mem_op, wb_sel, rd, rd_wen,
		halt, invalid);
endinterface
